//--- source/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

  // Fixed 12-bit codes, decoded from the full view of the word
  localparam logic [11:0] ENC_INC_SP = 12'hFDB;
  localparam logic [11:0] ENC_DEC_SP = 12'hFCB;

  // Opcode bytes of the instructions that carry an operand nibble n
  localparam logic [7:0] ENC_INC_M = 8'hF6;  // INC Mn
  localparam logic [7:0] ENC_DEC_M = 8'hF7;  // DEC Mn
  localparam logic [7:0] ENC_LD_AI = 8'hE0;  // LD A,i
  localparam logic [7:0] ENC_LD_MA = 8'hE8;  // LD Mn,A

  // Execution lengths in clock edges, counted from the accepting edge
  localparam int CYC_SHORT = 5;
  localparam int CYC_LONG  = 7;
  localparam int CNT_W     = $clog2(CYC_LONG + 1);

  // Opcode plus operand view of an instruction word
  typedef struct packed {
    logic [7:0] opcode;
    logic [3:0] n;  // RAM address or immediate
  } op_fields_t;

  // One word, read either as a whole code or as opcode and operand
  typedef union packed {
    logic [11:0] full;
    op_fields_t  opn;
  } instr_u;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_INC_M,
    OP_DEC_M,
    OP_INC_SP,
    OP_DEC_SP,
    OP_LD_AI,
    OP_LD_MA
  } op_e;

  // Decoded controls for one instruction
  typedef struct packed {
    op_e        op;
    logic [3:0] n;
    logic       mem_rd;   // Operand nibble is read from RAM
    logic       mem_wr;   // Result goes back to RAM
    logic       long_op;  // Read-modify-write takes the long sequence
  } ctl_t;

endpackage

`default_nettype wire

//--- source/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

  // Widest program counter the state struct carries
  localparam int PC_WIDTH_DEF = 12;

  // Host step request, held stable while req is high
  typedef struct packed {
    core_isa_pkg::instr_u instr;
  } step_req_t;

  // Debug access to the data RAM, honoured only while the core is idle
  typedef struct packed {
    logic       en;
    logic       we;     // 1 writes wdata, 0 reads into dbg_rdata
    logic [3:0] addr;
    logic [3:0] wdata;
  } dbg_req_t;

  // Architectural state as seen by the host
  typedef struct packed {
    logic [PC_WIDTH_DEF-1:0] pc;
    logic [3:0]              a;
    logic [7:0]              sp;
    logic                    c;  // Carry, or borrow after DEC Mn
    logic                    z;
  } core_state_t;

endpackage

`default_nettype wire

//--- source/step_sequencer.sv
`default_nettype none

module step_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req,
  input  core_bus_pkg::step_req_t  step_req,
  output logic                     ack,
  output logic                     busy,
  output core_isa_pkg::instr_u     instr,
  input  core_isa_pkg::ctl_t       ctl,
  output logic                     rd_stb,
  output logic                     wb_stb
);
  import core_isa_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_DONE
  } seq_state_e;

  seq_state_e       state_q;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cyc_len;
  logic             last_cyc;

  // Length follows the decode of the latched word, so it is stable in S_EXEC
  assign cyc_len  = ctl.long_op ? CNT_W'(CYC_LONG) : CNT_W'(CYC_SHORT);
  assign last_cyc = (cnt == cyc_len - CNT_W'(1));

  // The accepting edge is count 1, ack rises on the edge that makes it cyc_len
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt     <= '0;
      ack     <= 1'b0;
      instr   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            instr   <= step_req.instr;  // Word stays put for the whole sequence
            cnt     <= CNT_W'(1);
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          cnt <= cnt + CNT_W'(1);
          if (last_cyc) begin
            ack     <= 1'b1;
            state_q <= S_DONE;
          end
        end
        S_DONE: begin
          // Holding req here only stalls, nothing is executed again
          if (!req) begin
            ack     <= 1'b0;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // RAM data for the latched address is available by count 2
  assign rd_stb = (state_q == S_EXEC) && (cnt == CNT_W'(2));
  assign wb_stb = (state_q == S_EXEC) && last_cyc;  // Registers update with ack

  // Idle only once the host has dropped req and ack is back low
  assign busy = req || (state_q != S_IDLE);

endmodule

`default_nettype wire

//--- source/instr_decoder.sv
`default_nettype none

module instr_decoder (
  input  core_isa_pkg::instr_u instr,
  output core_isa_pkg::ctl_t   ctl
);
  import core_isa_pkg::*;

  always_comb begin
    ctl        = '0;
    ctl.op     = OP_NOP;
    ctl.n      = instr.opn.n;  // Low nibble is the operand whenever there is one

    // Whole-word codes first so FDB and FCB never hit the opcode table
    if (instr.full == ENC_INC_SP) begin
      ctl.op = OP_INC_SP;
    end else if (instr.full == ENC_DEC_SP) begin
      ctl.op = OP_DEC_SP;
    end else begin
      case (instr.opn.opcode)
        ENC_INC_M: begin
          ctl.op      = OP_INC_M;
          ctl.mem_rd  = 1'b1;
          ctl.mem_wr  = 1'b1;
          ctl.long_op = 1'b1;
        end
        ENC_DEC_M: begin
          ctl.op      = OP_DEC_M;
          ctl.mem_rd  = 1'b1;
          ctl.mem_wr  = 1'b1;
          ctl.long_op = 1'b1;
        end
        ENC_LD_AI: begin
          ctl.op = OP_LD_AI;  // Immediate travels in n
        end
        ENC_LD_MA: begin
          ctl.op     = OP_LD_MA;
          ctl.mem_wr = 1'b1;
        end
        default: begin
          // Anything else runs as a short NOP
          ctl.op = OP_NOP;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/core_datapath.sv
`default_nettype none

module core_datapath #(
  parameter int PC_WIDTH = 12
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  core_isa_pkg::ctl_t        ctl,
  input  logic                      rd_stb,
  input  logic                      wb_stb,
  output logic [3:0]                ram_addr,
  output logic                      ram_we,
  output logic [3:0]                ram_wdata,
  input  logic [3:0]                ram_rdata,
  output core_bus_pkg::core_state_t state
);
  import core_isa_pkg::*;

  logic [PC_WIDTH-1:0] pc;
  logic [3:0]          a;
  logic [7:0]          sp;
  logic                c;
  logic                z;

  logic [3:0] opnd;     // RAM nibble captured in the read phase
  logic [4:0] alu_sum;  // Bit 4 is carry for INC and borrow for DEC
  logic       alu_zero;

  // Operand nibble is sampled once, in the read phase
  always_ff @(posedge clk) begin
    if (rd_stb && ctl.mem_rd) begin
      opnd <= ram_rdata;
    end
  end

  always_comb begin
    if (ctl.op == OP_DEC_M) begin
      alu_sum = {1'b0, opnd} - 5'd1;
    end else begin
      alu_sum = {1'b0, opnd} + 5'd1;
    end
    alu_zero = (alu_sum[3:0] == 4'h0);
  end

  assign ram_addr  = ctl.n;
  assign ram_we    = wb_stb && ctl.mem_wr;
  assign ram_wdata = (ctl.op == OP_LD_MA) ? a : alu_sum[3:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
      a  <= '0;
      sp <= '0;
      c  <= 1'b0;
      z  <= 1'b0;
    end else if (wb_stb) begin
      pc <= pc + PC_WIDTH'(1);  // Every instruction, NOP included
      case (ctl.op)
        OP_INC_M, OP_DEC_M: begin
          c <= alu_sum[4];
          z <= alu_zero;
        end
        OP_INC_SP: sp <= sp + 8'd1;
        OP_DEC_SP: sp <= sp - 8'd1;
        OP_LD_AI:  a  <= ctl.n;
        default: begin
          // LD Mn,A only writes RAM and a NOP only moves PC
        end
      endcase
    end
  end

  // A narrower PC is zero-extended into the state struct
  always_comb begin
    state                = '0;
    state.pc[PC_WIDTH-1:0] = pc;
    state.a              = a;
    state.sp             = sp;
    state.c              = c;
    state.z              = z;
  end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none

module data_ram (
  input  logic                   clk,
  input  logic [3:0]             addr,
  input  logic                   we,
  input  logic [3:0]             wdata,
  output logic [3:0]             rdata,
  input  core_bus_pkg::dbg_req_t dbg,
  output logic [3:0]             dbg_rdata,
  input  logic                   busy
);

  logic [3:0] mem [16];
  logic       dbg_ok;

  // The host reaches the array only between steps
  assign dbg_ok = dbg.en && !busy;

  always_ff @(posedge clk) begin
    // Core writes happen only while busy, so the two never collide
    if (we) begin
      mem[addr] <= wdata;
    end else if (dbg_ok && dbg.we) begin
      mem[dbg.addr] <= dbg.wdata;
    end
  end

  // Both read ports are registered, one cycle from address to data
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
    if (dbg_ok && !dbg.we) begin
      dbg_rdata <= mem[dbg.addr];  // Holds the last read between strobes
    end
  end

endmodule

`default_nettype wire

//--- source/nib_core_top.sv
`default_nettype none

module nib_core_top #(
  parameter int PC_WIDTH = 12
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  input  core_bus_pkg::step_req_t   step_req,
  output logic                      ack,
  input  core_bus_pkg::dbg_req_t    dbg,
  output logic [3:0]                dbg_rdata,
  output core_bus_pkg::core_state_t state
);
  import core_isa_pkg::*;

  instr_u     instr;
  ctl_t       ctl;
  logic       busy;
  logic       rd_stb;
  logic       wb_stb;
  logic [3:0] ram_addr;
  logic       ram_we;
  logic [3:0] ram_wdata;
  logic [3:0] ram_rdata;

  // Handshake, latched instruction and phase strobes
  step_sequencer u_step_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .step_req (step_req),
    .ack      (ack),
    .busy     (busy),
    .instr    (instr),
    .ctl      (ctl),
    .rd_stb   (rd_stb),
    .wb_stb   (wb_stb)
  );

  instr_decoder u_instr_decoder (
    .instr (instr),
    .ctl   (ctl)
  );

  core_datapath #(
    .PC_WIDTH (PC_WIDTH)
  ) u_core_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl),
    .rd_stb    (rd_stb),
    .wb_stb    (wb_stb),
    .ram_addr  (ram_addr),
    .ram_we    (ram_we),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .state     (state)
  );

  // Debug port is locked out whenever the sequencer reports busy
  data_ram u_data_ram (
    .clk       (clk),
    .addr      (ram_addr),
    .we        (ram_we),
    .wdata     (ram_wdata),
    .rdata     (ram_rdata),
    .dbg       (dbg),
    .dbg_rdata (dbg_rdata),
    .busy      (busy)
  );

endmodule

`default_nettype wire

//--- tb/step_sequencer_properties.sv
`default_nettype none

module step_sequencer_properties (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic ack,
  input logic rd_stb,
  input logic wb_stb
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack only answers a request that is standing
  ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  ack_held_until_req_low: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && req) |=> ack)
    else $error("ack fell before req was released");

  // Phase strobes fall between acceptance of a request and its ack
  strobes_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_stb || wb_stb) |-> (req && !ack))
    else $error("phase strobe outside execution");

endmodule

bind step_sequencer step_sequencer_properties u_step_sequencer_properties (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .ack    (ack),
  .rd_stb (rd_stb),
  .wb_stb (wb_stb)
);

`default_nettype wire

//--- tb/nib_core_tb.sv
`default_nettype none

module nib_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import core_isa_pkg::*;
  import core_bus_pkg::*;

  localparam int TB_CYC_SHORT = 5;
  localparam int TB_CYC_LONG  = 7;
  localparam int ACK_TIMEOUT  = 50;  // Edges allowed for any single handshake wait
  localparam int HOLD_CYCLES  = 20;

  logic        clk;
  logic        rst_n;
  logic        req;
  step_req_t   step_req;
  logic        ack;
  dbg_req_t    dbg;
  logic [3:0]  dbg_rdata;
  core_state_t state;

  // Reference model of the architectural state
  logic [11:0] m_pc;
  logic [3:0]  m_a;
  logic [7:0]  m_sp;
  logic        m_c;
  logic        m_z;
  logic [3:0]  m_ram [16];

  int errors;
  int checks;
  int seed;

  nib_core_top #(
    .PC_WIDTH (12)
  ) u_nib_core_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .step_req  (step_req),
    .ack       (ack),
    .dbg       (dbg),
    .dbg_rdata (dbg_rdata),
    .state     (state)
  );

  always #4 clk = ~clk;

  task automatic report_err(input string msg);
    errors++;
    $display("ERR @%0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: %s", what);
  endtask

  task automatic ram_write(input logic [3:0] addr, input logic [3:0] data);
    @(posedge clk);
    dbg <= '{en: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    dbg <= '0;
  endtask

  task automatic ram_read(input logic [3:0] addr, output logic [3:0] data);
    @(posedge clk);
    dbg <= '{en: 1'b1, we: 1'b0, addr: addr, wdata: 4'h0};
    @(posedge clk);
    dbg <= '0;
    @(negedge clk);
    data = dbg_rdata;  // Registered on the edge after the strobe
  endtask

  // Raises req and counts edges up to and including the one that raises ack
  task automatic issue_step(input logic [11:0] code, output int cyc);
    @(posedge clk);
    step_req.instr.full <= code;
    req <= 1'b1;
    cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
      @(negedge clk);
    end while (!ack && cyc < ACK_TIMEOUT);
    if (!ack) begin
      report_timeout($sformatf("no ack for instruction %03h", code));
    end
  endtask

  task automatic release_req();
    int wait_cyc;
    @(posedge clk);
    req <= 1'b0;
    wait_cyc = 0;
    do begin
      @(posedge clk);
      wait_cyc++;
      @(negedge clk);
    end while (ack && wait_cyc < ACK_TIMEOUT);
    if (ack) begin
      report_timeout("ack stayed high after req was released");
    end
  endtask

  // Applies the instruction rules to the model and returns the expected length
  task automatic model_exec(input logic [11:0] code, output int exp_cyc);
    logic [3:0] n;
    logic [3:0] old;
    n       = code[3:0];
    old     = m_ram[n];
    exp_cyc = TB_CYC_SHORT;
    m_pc    = m_pc + 12'd1;
    if (code == 12'hFDB) begin
      m_sp = m_sp + 8'd1;
    end else if (code == 12'hFCB) begin
      m_sp = m_sp - 8'd1;
    end else if (code[11:4] == 8'hF6) begin
      m_ram[n] = old + 4'd1;
      m_c      = (old == 4'hF);  // Carry out of the nibble
      m_z      = (m_ram[n] == 4'h0);
      exp_cyc  = TB_CYC_LONG;
    end else if (code[11:4] == 8'hF7) begin
      m_ram[n] = old - 4'd1;
      m_c      = (old == 4'h0);  // Borrow
      m_z      = (m_ram[n] == 4'h0);
      exp_cyc  = TB_CYC_LONG;
    end else if (code[11:4] == 8'hE0) begin
      m_a = n;
    end else if (code[11:4] == 8'hE8) begin
      m_ram[n] = m_a;
    end
  endtask

  task automatic compare_state(input string tag);
    checks++;
    if (state.pc !== m_pc) begin
      report_err($sformatf("%s pc %03h, expected %03h", tag, state.pc, m_pc));
    end
    if (state.a !== m_a) begin
      report_err($sformatf("%s A %h, expected %h", tag, state.a, m_a));
    end
    if (state.sp !== m_sp) begin
      report_err($sformatf("%s SP %02h, expected %02h", tag, state.sp, m_sp));
    end
    if (state.c !== m_c || state.z !== m_z) begin
      report_err($sformatf("%s C/Z %b%b, expected %b%b", tag, state.c, state.z, m_c, m_z));
    end
  endtask

  task automatic check_nibble(input logic [3:0] addr);
    logic [3:0] got;
    ram_read(addr, got);
    checks++;
    if (got !== m_ram[addr]) begin
      report_err($sformatf("RAM[%0d] reads %h, expected %h", addr, got, m_ram[addr]));
    end
  endtask

  // State is compared in the cycle where ack is first high
  task automatic exec_and_check(input logic [11:0] code);
    int exp_cyc;
    int got_cyc;
    model_exec(code, exp_cyc);
    issue_step(code, got_cyc);
    checks++;
    if (got_cyc != exp_cyc) begin
      report_err($sformatf("instr %03h took %0d cycles, expected %0d", code, got_cyc, exp_cyc));
    end
    compare_state($sformatf("instr %03h", code));
    release_req();
  endtask

  task automatic reset_values();
    checks++;
    if (ack !== 1'b0 || state !== '0) begin
      report_err($sformatf("after reset ack %b state %h, expected all zero", ack, state));
    end
  endtask

  task automatic inc_every_nibble();
    for (int n = 0; n < 16; n++) begin
      m_ram[n] = 4'(n + 2);  // 13 holds 15 so the wrap is covered
      ram_write(4'(n), m_ram[n]);
    end
    for (int n = 0; n < 16; n++) begin
      exec_and_check({8'hF6, 4'(n)});
      check_nibble(4'(n));
    end
  endtask

  task automatic dec_every_nibble();
    for (int n = 0; n < 16; n++) begin
      m_ram[n] = (n == 5) ? 4'h0 : 4'($random(seed));
      ram_write(4'(n), m_ram[n]);
    end
    for (int n = 0; n < 16; n++) begin
      exec_and_check({8'hF7, 4'(n)});
      check_nibble(4'(n));
    end
  endtask

  task automatic sp_steps();
    int r;
    exec_and_check(12'hFCB);  // 00 wraps to FF
    exec_and_check(12'hFDB);  // And back to 00
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      exec_and_check(r[0] ? 12'hFDB : 12'hFCB);
    end
    for (int n = 0; n < 16; n++) begin
      check_nibble(4'(n));
    end
  endtask

  task automatic load_and_store();
    int r;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      exec_and_check({8'hE0, r[3:0]});
      exec_and_check({8'hE8, r[7:4]});
      check_nibble(r[7:4]);
    end
  endtask

  task automatic undefined_codes_nop();
    logic [11:0] codes [5] = '{12'h000, 12'h123, 12'hFDC, 12'hE1A, 12'hF5F};
    for (int i = 0; i < 5; i++) begin
      exec_and_check(codes[i]);
    end
  endtask

  task automatic held_req_backpressure();
    int exp_cyc;
    int got_cyc;
    model_exec(12'hFDB, exp_cyc);
    issue_step(12'hFDB, got_cyc);
    repeat (HOLD_CYCLES) @(negedge clk);
    checks++;
    if (!ack) begin
      report_err("ack dropped while req was still held");
    end
    compare_state("held req");  // A second execution would move PC again
    release_req();
    compare_state("after release");
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    req      = 1'b0;
    step_req = '0;
    dbg      = '0;
    errors   = 0;
    checks   = 0;
    seed     = 32'h00fadb9f;
    m_pc     = '0;
    m_a      = '0;
    m_sp     = '0;
    m_c      = 1'b0;
    m_z      = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_values();
    inc_every_nibble();
    dec_every_nibble();
    sp_steps();
    load_and_store();
    undefined_codes_nop();
    held_req_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/core_isa_pkg.sv
source/core_bus_pkg.sv
source/step_sequencer.sv
source/instr_decoder.sv
source/core_datapath.sv
source/data_ram.sv
source/nib_core_top.sv
tb/step_sequencer_properties.sv
tb/nib_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module nib_core_tb -o nib_core_sim \
  && ./obj_dir/nib_core_sim | tee /dev/stderr | grep -q "^SIMULATION PASSED$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
